// ==== Makefile ====
TOP = tb_execTop

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== hdl/aluCore.sv ====
////////////////////////////////////////
// 16-bit ALU with input inversion,
// carry-in, overflow and zero flags.
////////////////////////////////////////
module aluCore (
   input  logic [15:0]       inA,
   input  logic [15:0]       inB,
   input  execPkg::ctrlT     ctrl,
   output logic [15:0]       aluOut,
   output execPkg::aluFlagsT flags
);
   import execPkg::*;

   logic [15:0] opA;       // A after optional inversion.
   logic [15:0] opB;       // B after optional inversion.
   logic [3:0]  sh;        // Shift amount.
   logic [16:0] sum;       // Adder with carry out.
   logic [31:0] rotL;
   logic [31:0] rotR;
   logic        isAdd;
   logic        sOfl;      // Two's complement overflow.

   assign opA   = ctrl.invA ? ~inA : inA;
   assign opB   = ctrl.invB ? ~inB : inB;
   assign sh    = opB[3:0];
   assign sum   = {1'b0, opA} + {1'b0, opB} + {16'b0, ctrl.cin};
   assign rotL  = {opA, opA} << sh;            // Upper half holds the rotate.
   assign rotR  = {opA, opA} >> sh;            // Lower half holds the rotate.
   assign isAdd = (ctrl.aluOp == ALU_ADD);

   ////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////
   always_comb begin
      case (ctrl.aluOp)
         ALU_ROL:  aluOut = rotL[31:16];
         ALU_SLL:  aluOut = opA << sh;
         ALU_ROR:  aluOut = rotR[15:0];
         ALU_SRL:  aluOut = opA >> sh;
         ALU_ADD:  aluOut = sum[15:0];
         ALU_OR:   aluOut = ctrl.cin ? opB : (opA | opB);  // Carry-in gives load-byte.
         ALU_XOR:  aluOut = opA ^ opB;
         default:  aluOut = opA & ~opB;                   // ANDN.
      endcase
   end

   ////////////////////////////////////////
   // Flags
   ////////////////////////////////////////
   assign sOfl       = (opA[15] == opB[15]) & (sum[15] != opA[15]);
   assign flags.ofl  = isAdd & (ctrl.signedOp ? sOfl : sum[16]);  // Unsigned uses carry.
   assign flags.cout = isAdd & sum[16];
   assign flags.zero = (aluOut == 16'h0000);
   assign flags.sgn  = aluOut[15];

endmodule

// ==== hdl/branchUnit.sv ====
////////////////////////////////////////
// Branch condition, PC-relative target
// and next PC select.
////////////////////////////////////////
`include "execDefs.svh"

module branchUnit (
   input  logic [15:0]       pc,
   input  logic [15:0]       instr,
   input  logic [15:0]       aluOut,
   input  execPkg::aluFlagsT flags,
   input  execPkg::ctrlT     ctrl,
   output logic [15:0]       newPc
);
   import execPkg::*;

   logic [15:0] disp;      // Sign-extended displacement.
   logic [15:0] target;    // PC-relative destination.
   logic        taken;

   assign disp   = ctrl.immLong ?
                   {{5{instr[`DISP_HI]}}, instr[`DISP_HI:0]} :
                   {{8{instr[`IMM8_HI]}}, instr[`IMM8_HI:0]};
   assign target = pc + disp;

   ////////////////////////////////////////
   // Condition on regA
   ////////////////////////////////////////
   always_comb begin
      case (ctrl.brType)
         BR_EQZ:  taken = flags.zero;
         BR_NEZ:  taken = ~flags.zero;
         BR_LTZ:  taken = flags.sgn;
         BR_GEZ:  taken = ~flags.sgn;
         default: taken = 1'b0;
      endcase
   end

   // Register jump first, then relative, then fall through.
   always_comb begin
      if (ctrl.jumpReg) begin
         newPc = aluOut;                   // regA + imm8.
      end else if (taken | ctrl.jumpRel) begin
         newPc = target;
      end else begin
         newPc = pc;
      end
   end

endmodule

// ==== hdl/condResult.sv ====
////////////////////////////////////////
// Writeback value: set-on-condition,
// bit reverse, link and ALU pass.
////////////////////////////////////////
module condResult (
   input  logic [15:0]       aluOut,
   input  execPkg::aluFlagsT flags,
   input  execPkg::ctrlT     ctrl,
   input  logic [15:0]       pc,
   output logic [15:0]       result
);
   import execPkg::*;

   logic        less;      // Sign of regA - regB, corrected by overflow.
   logic [15:0] rev;       // aluOut bit reversed.

   assign less = flags.sgn ^ flags.ofl;

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         rev[i] = aluOut[15-i];
      end
   end

   always_comb begin
      case (ctrl.resSel)
         RES_EQ:   result = {15'b0, flags.zero};
         RES_LT:   result = {15'b0, less};
         RES_LE:   result = {15'b0, less | flags.zero};
         RES_CO:   result = {15'b0, flags.cout};     // Carry of regA + regB.
         RES_REV:  result = rev;                     // B is zero, so this is regA.
         RES_LINK: result = pc;                      // Return address.
         default:  result = aluOut;
      endcase
   end

endmodule

// ==== hdl/execControl.sv ====
////////////////////////////////////////
// Opcode decode, req/ack FSM and the
// response register.
////////////////////////////////////////
module execControl (
   input  logic              clk,
   input  logic              rstN,
   input  logic              req,
   output logic              ack,
   input  execPkg::opcodeT   opcode,
   input  logic [1:0]        aluFunc,
   output execPkg::ctrlT     ctrl,
   input  logic [15:0]       result,
   input  logic [15:0]       newPc,
   input  logic [15:0]       bOperand,
   output execPkg::execRespT response
);
   import execPkg::*;

   typedef enum logic [1:0] {IDLE, EXEC, DONE, RELEASE} stateT;

   stateT state;

   // ADD, SUB (B - A), XOR, ANDN by function code.
   function automatic ctrlT arithCtrl(input logic [1:0] func, input bSrcT src);
      ctrlT c;
      c          = '0;
      c.bSrc     = src;
      c.aluOp    = func[1] ? aluOpT'({1'b1, func}) : ALU_ADD;
      c.invA     = (func == 2'b01);
      c.cin      = (func == 2'b01);
      c.signedOp = ~func[1];              // Logic ops zero-extend.
      return c;
   endfunction

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////
   always_comb begin
      ctrl = '0;
      case (opcode)
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: ctrl = arithCtrl(opcode[1:0], B_IMM5);
         OP_ALUADD:                           ctrl = arithCtrl(aluFunc, B_REG);
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            ctrl.aluOp = aluOpT'({1'b0, opcode[1:0]});
            ctrl.bSrc  = B_IMM5;
         end
         OP_ALUSHIFT: ctrl.aluOp = aluOpT'({1'b0, aluFunc});
         OP_LBI: begin
            ctrl.aluOp    = ALU_OR;
            ctrl.bSrc     = B_IMM8;
            ctrl.signedOp = 1'b1;
            ctrl.cin      = 1'b1;          // Pass B.
         end
         OP_SLBI: begin
            ctrl.aluOp = ALU_OR;
            ctrl.bSrc  = B_SLBI;
            ctrl.cin   = 1'b1;
         end
         OP_BTR: begin
            ctrl.aluOp  = ALU_OR;
            ctrl.zeroB  = 1'b1;
            ctrl.resSel = RES_REV;
         end
         OP_SEQ, OP_SLT, OP_SLE: begin     // regA - regB.
            ctrl.aluOp    = ALU_ADD;
            ctrl.invB     = 1'b1;
            ctrl.cin      = 1'b1;
            ctrl.signedOp = 1'b1;
            ctrl.resSel   = resSelT'(3'(opcode[1:0]) + 3'd1);
         end
         OP_SCO: begin
            ctrl.aluOp  = ALU_ADD;
            ctrl.resSel = RES_CO;
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctrl.aluOp  = ALU_OR;
            ctrl.zeroB  = 1'b1;
            ctrl.brType = brTypeT'(3'(opcode[1:0]) + 3'd1);  // EQZ..GEZ in order.
         end
         OP_J, OP_JAL: begin
            ctrl.aluOp   = ALU_OR;
            ctrl.zeroB   = 1'b1;
            ctrl.jumpRel = 1'b1;
            ctrl.immLong = 1'b1;
            ctrl.resSel  = opcode[1] ? RES_LINK : RES_ALU;
         end
         OP_JR, OP_JALR: begin
            ctrl.aluOp    = ALU_ADD;
            ctrl.bSrc     = B_IMM8;
            ctrl.signedOp = 1'b1;
            ctrl.jumpReg  = 1'b1;
            ctrl.resSel   = opcode[1] ? RES_LINK : RES_ALU;
         end
         default: begin                    // NOP and unknown opcodes pass regA.
            ctrl.aluOp = ALU_OR;
            ctrl.zeroB = 1'b1;
         end
      endcase
   end

   ////////////////////////////////////////
   // Handshake and capture
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state    <= IDLE;
         response <= '0;
      end else begin
         case (state)
            IDLE:    if (req) state <= EXEC;        // First edge samples req.
            EXEC: begin
               response.result <= result;           // Captured once per request.
               response.newPc  <= newPc;
               response.bValue <= bOperand;
               state           <= DONE;
            end
            DONE:    if (!req) state <= RELEASE;    // Held while req stays high.
            default: state <= IDLE;                 // Low phase complete.
         endcase
      end
   end

   assign ack = (state == DONE);

endmodule

// ==== hdl/execPkg.sv ====
////////////////////////////////////////
// Opcode, ALU, operand, result and
// branch enums plus the packed request,
// control, flag and response structs.
////////////////////////////////////////
package execPkg;
   `include "execDefs.svh"

   typedef enum logic [4:0] {
      OP_NOP      = 5'b00001,
      OP_J        = 5'b00100, OP_JR    = 5'b00101, OP_JAL  = 5'b00110, OP_JALR = 5'b00111,
      OP_ADDI     = 5'b01000, OP_SUBI  = 5'b01001, OP_XORI = 5'b01010, OP_ANDNI = 5'b01011,
      OP_BEQZ     = 5'b01100, OP_BNEZ  = 5'b01101, OP_BLTZ = 5'b01110, OP_BGEZ = 5'b01111,
      OP_SLBI     = 5'b10010,
      OP_ROLI     = 5'b10100, OP_SLLI  = 5'b10101, OP_RORI = 5'b10110, OP_SRLI = 5'b10111,
      OP_LBI      = 5'b11000, OP_BTR   = 5'b11001,
      OP_ALUSHIFT = 5'b11010, OP_ALUADD = 5'b11011,
      OP_SEQ      = 5'b11100, OP_SLT   = 5'b11101, OP_SLE  = 5'b11110, OP_SCO  = 5'b11111
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,    // Shift group, low bits match opcode.
      ALU_ADD, ALU_OR, ALU_XOR, ALU_ANDN
   } aluOpT;

   typedef enum logic [1:0] {B_REG, B_IMM5, B_IMM8, B_SLBI} bSrcT;

   typedef enum logic [2:0] {
      RES_ALU, RES_EQ, RES_LT, RES_LE, RES_CO, RES_REV, RES_LINK
   } resSelT;

   typedef enum logic [2:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} brTypeT;

   typedef struct packed {
      logic [`EXEC_WIDTH-1:0] instr;
      logic [`EXEC_WIDTH-1:0] pc;       // Already incremented.
      logic [`EXEC_WIDTH-1:0] regA;
      logic [`EXEC_WIDTH-1:0] regB;
   } execReqT;

   typedef struct packed {
      aluOpT  aluOp;
      bSrcT   bSrc;
      logic   zeroB;                    // B forced to zero.
      logic   invA;
      logic   invB;
      logic   cin;                      // On OR, passes B alone.
      logic   signedOp;
      resSelT resSel;
      brTypeT brType;
      logic   immLong;                  // 11-bit displacement.
      logic   jumpReg;                  // Target from ALU.
      logic   jumpRel;                  // Unconditional PC-relative.
   } ctrlT;

   typedef struct packed {
      logic zero;
      logic ofl;
      logic sgn;
      logic cout;
   } aluFlagsT;

   typedef struct packed {
      logic [`EXEC_WIDTH-1:0] result;
      logic [`EXEC_WIDTH-1:0] newPc;
      logic [`EXEC_WIDTH-1:0] bValue;   // Store data for the memory stage.
   } execRespT;
endpackage

// ==== hdl/execTop.sv ====
////////////////////////////////////////
// Execute stage top: control and
// datapath instances.
////////////////////////////////////////
`include "execDefs.svh"

module execTop (
   input  logic              clk,
   input  logic              rstN,
   input  logic              req,
   output logic              ack,
   input  execPkg::execReqT  request,
   output execPkg::execRespT response
);
   import execPkg::*;

   ctrlT        ctrl;
   logic [15:0] bOperand;
   logic [15:0] aluOut;
   aluFlagsT    flags;
   logic [15:0] result;
   logic [15:0] newPc;

   execControl uControl (
      .clk(clk), .rstN(rstN), .req(req), .ack(ack),
      .opcode(opcodeT'(request.instr[`OPC_HI:`OPC_LO])),
      .aluFunc(request.instr[`FUNC_HI:0]),
      .ctrl(ctrl), .result(result), .newPc(newPc), .bOperand(bOperand),
      .response(response)
   );

   operandMux uOperand (.request(request), .ctrl(ctrl), .bOperand(bOperand));

   aluCore uAlu (
      .inA(request.regA), .inB(bOperand), .ctrl(ctrl), .aluOut(aluOut), .flags(flags)
   );

   condResult uCond (
      .aluOut(aluOut), .flags(flags), .ctrl(ctrl), .pc(request.pc), .result(result)
   );

   branchUnit uBranch (
      .pc(request.pc), .instr(request.instr), .aluOut(aluOut), .flags(flags),
      .ctrl(ctrl), .newPc(newPc)
   );

endmodule

// ==== hdl/operandMux.sv ====
////////////////////////////////////////
// Immediate extraction and extension,
// ALU B operand select.
////////////////////////////////////////
`include "execDefs.svh"

module operandMux (
   input  execPkg::execReqT request,
   input  execPkg::ctrlT    ctrl,
   output logic [15:0]      bOperand
);
   import execPkg::*;

   logic [15:0] imm5;    // Extended 5-bit immediate.
   logic [15:0] imm8;    // Extended 8-bit immediate.
   logic [15:0] slbi;    // Shifted low byte plus immediate.

   ////////////////////////////////////////
   // Immediates
   ////////////////////////////////////////
   assign imm5 = ctrl.signedOp ?
                 {{11{request.instr[`IMM5_HI]}}, request.instr[`IMM5_HI:0]} :
                 {11'b0, request.instr[`IMM5_HI:0]};
   assign imm8 = ctrl.signedOp ?
                 {{8{request.instr[`IMM8_HI]}}, request.instr[`IMM8_HI:0]} :
                 {8'b0, request.instr[`IMM8_HI:0]};
   assign slbi = {request.regA[7:0], request.instr[`IMM8_HI:0]};  // (Rs << 8) | imm.

   ////////////////////////////////////////
   // B select
   ////////////////////////////////////////
   always_comb begin
      if (ctrl.zeroB) begin
         bOperand = 16'h0000;                // Branches and BTR pass regA.
      end else begin
         case (ctrl.bSrc)
            B_REG:   bOperand = request.regB;
            B_IMM5:  bOperand = imm5;
            B_IMM8:  bOperand = imm8;
            default: bOperand = slbi;
         endcase
      end
   end

endmodule

// ==== include/execDefs.svh ====
////////////////////////////////////////
// Data width and instruction field
// positions for the execute stage.
////////////////////////////////////////
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define EXEC_WIDTH 16      // Datapath width.

`define OPC_HI     15      // Opcode field.
`define OPC_LO     11
`define RS_LO      8       // Rs field starts here.
`define IMM5_HI    4       // 5-bit immediate, bits 4..0.
`define IMM8_HI    7       // 8-bit immediate, bits 7..0.
`define DISP_HI    10      // 11-bit jump displacement.
`define FUNC_HI    1       // ALU function field, bits 1..0.

`endif

// ==== project.f ====
+incdir+include
hdl/execPkg.sv
hdl/operandMux.sv
hdl/aluCore.sv
hdl/condResult.sv
hdl/branchUnit.sv
hdl/execControl.sv
hdl/execTop.sv
sim/tb_execTop.sv

// ==== sim/tb_execTop.sv ====
////////////////////////////////////////
// Testbench for the execute stage: LFSR
// stimulus, reference model, handshake
// assertions and a watchdog.
////////////////////////////////////////
module tb_execTop;
   import execPkg::*;

   localparam int RESET_CYCLES = 4;
   localparam int NUM_EDGE     = 12;        // Directed edge cases.
   localparam int NUM_RANDOM   = 400;
   localparam int NUM_TX       = NUM_EDGE + NUM_RANDOM;
   localparam int MAX_WAIT     = 8;         // Cycles allowed for each ack edge.

   logic        clk;
   logic        rstN;
   logic        req;
   logic        ack;
   execReqT     request;
   execRespT    response;
   logic [31:0] lfsr;                       // Random source state.
   int          errors;
   int          checks;

   execTop uut (
      .clk(clk), .rstN(rstN), .req(req), .ack(ack), .request(request), .response(response)
   );

   always #5 clk = ~clk;                    // Period 10.

   ////////////////////////////////////////
   // Handshake assertions
   ////////////////////////////////////////
   task automatic handshakeFault(input string what);
      errors++;
      $display("Handshake error: %s", what);
   endtask

   assert property (@(posedge clk) disable iff (!rstN) $rose(req) |-> !ack)
      else handshakeFault("ack was already high when req rose");
   assert property (@(posedge clk) disable iff (!rstN) $rose(req) |=> !ack)
      else handshakeFault("ack rose one cycle after req, too early");
   assert property (@(posedge clk) disable iff (!rstN) $rose(req) |-> ##2 ack)
      else handshakeFault("ack did not rise two cycles after req");
   assert property (@(posedge clk) disable iff (!rstN) $fell(req) |-> ack)
      else handshakeFault("req dropped while ack was low");
   assert property (@(posedge clk) disable iff (!rstN) $fell(req) |=> !ack)
      else handshakeFault("ack stayed high more than one cycle after req fell");
   assert property (@(posedge clk) disable iff (!rstN) $rose(ack) |-> req)
      else handshakeFault("ack rose without a pending req");
   assert property (@(posedge clk) disable iff (!rstN) ack |=> $stable(response))
      else handshakeFault("response changed while ack was high");

   ////////////////////////////////////////
   // Random source
   ////////////////////////////////////////
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);   // Galois form.
   endfunction

   task automatic randomBits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[14:0], lfsr[0]};          // One step per bit.
         lfsr = lfsrNext(lfsr);
      end
   endtask

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic logic [15:0] shiftRef(input logic [1:0] kind, input logic [15:0] a,
                                            input logic [3:0] n);
      int amt;
      amt = int'(n);
      case (kind)
         2'b00:   return (a << amt) | (a >> (16 - amt));  // Rotate left.
         2'b01:   return a << amt;
         2'b10:   return (a >> amt) | (a << (16 - amt));  // Rotate right.
         default: return a >> amt;
      endcase
   endfunction

   function automatic execRespT expectedResp(input execReqT r);
      execRespT    e;
      logic [4:0]  op;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] sImm5;
      logic [15:0] zImm5;
      logic [15:0] sImm8;
      logic [15:0] sDisp;
      logic [16:0] wide;
      op    = r.instr[15:11];
      a     = r.regA;
      b     = r.regB;
      sImm5 = {{11{r.instr[4]}}, r.instr[4:0]};
      zImm5 = {11'b0, r.instr[4:0]};
      sImm8 = {{8{r.instr[7]}}, r.instr[7:0]};
      sDisp = {{5{r.instr[10]}}, r.instr[10:0]};
      wide  = {1'b0, a} + {1'b0, b};
      e.result = a;                           // Default: NOP passes regA.
      e.newPc  = r.pc;
      e.bValue = 16'h0000;
      case (op)
         OP_ADDI:  begin e.bValue = sImm5; e.result = a + sImm5; end
         OP_SUBI:  begin e.bValue = sImm5; e.result = sImm5 - a; end
         OP_XORI:  begin e.bValue = zImm5; e.result = a ^ zImm5; end
         OP_ANDNI: begin e.bValue = zImm5; e.result = a & ~zImm5; end
         OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
            e.bValue = zImm5;
            e.result = shiftRef(op[1:0], a, zImm5[3:0]);
         end
         OP_ALUSHIFT: begin e.bValue = b; e.result = shiftRef(r.instr[1:0], a, b[3:0]); end
         OP_ALUADD: begin
            e.bValue = b;
            case (r.instr[1:0])
               2'b00:   e.result = a + b;
               2'b01:   e.result = b - a;     // Subtract is Rt minus Rs.
               2'b10:   e.result = a ^ b;
               default: e.result = a & ~b;
            endcase
         end
         OP_LBI:  begin e.bValue = sImm8; e.result = sImm8; end
         OP_SLBI: begin e.result = (a << 8) | {8'b0, r.instr[7:0]}; e.bValue = e.result; end
         OP_BTR:  for (int i = 0; i < 16; i++) e.result[i] = a[15-i];
         OP_SEQ:  begin e.bValue = b; e.result = {15'b0, a == b}; end
         OP_SLT:  begin e.bValue = b; e.result = {15'b0, $signed(a) < $signed(b)}; end
         OP_SLE:  begin e.bValue = b; e.result = {15'b0, $signed(a) <= $signed(b)}; end
         OP_SCO:  begin e.bValue = b; e.result = {15'b0, wide[16]}; end
         OP_BEQZ: if (a == 16'h0) e.newPc = r.pc + sImm8;
         OP_BNEZ: if (a != 16'h0) e.newPc = r.pc + sImm8;
         OP_BLTZ: if (a[15]) e.newPc = r.pc + sImm8;
         OP_BGEZ: if (!a[15]) e.newPc = r.pc + sImm8;
         OP_J:    e.newPc = r.pc + sDisp;
         OP_JAL:  begin e.newPc = r.pc + sDisp; e.result = r.pc; end
         OP_JR:   begin e.bValue = sImm8; e.newPc = a + sImm8; e.result = a + sImm8; end
         OP_JALR: begin e.bValue = sImm8; e.newPc = a + sImm8; e.result = r.pc; end
         default: ;
      endcase
      return e;
   endfunction

   ////////////////////////////////////////
   // Exchange and checks
   ////////////////////////////////////////
   task automatic checkValue(input string name, input logic [15:0] want,
                             input logic [15:0] got);
      checks++;
      assert (got === want)
         else begin
            errors++;
            $display("Fail %s: expected 0x%04h, got 0x%04h", name, want, got);
         end
   endtask

   task automatic checkResponse(input execRespT want);
      checkValue("response.result", want.result, response.result);
      checkValue("response.newPc", want.newPc, response.newPc);
      checkValue("response.bValue", want.bValue, response.bValue);
   endtask

   // Full four-phase exchange, req held for extra cycles after ack.
   task automatic runExchange(input execReqT r, input int hold);
      execRespT want;
      int       waited;
      want = expectedResp(r);
      @(posedge clk);
      request <= r;
      req     <= 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!ack && waited < MAX_WAIT);
      if (!ack) handshakeFault("no ack for a pending req");
      checkResponse(want);
      repeat (hold) @(negedge clk);
      @(posedge clk);
      req <= 1'b0;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (ack && waited < MAX_WAIT);
      if (ack) handshakeFault("ack never fell after req dropped");
      checkResponse(want);                    // Held after release.
   endtask

   function automatic execReqT makeReq(input logic [4:0] op, input logic [10:0] low,
                                       input logic [15:0] pc, input logic [15:0] a,
                                       input logic [15:0] b);
      return '{instr: {op, low}, pc: pc, regA: a, regB: b};
   endfunction

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      execReqT     r;
      logic [15:0] bits;
      clk     = 1'b0;
      errors  = 0;
      checks  = 0;
      lfsr    = 32'h2ba85def;
      rstN    <= 1'b0;
      req     <= 1'b0;
      request <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkValue("ack", 16'h0000, {15'b0, ack});
      checkResponse('0);

      // Overflow edges, reversal, branches and jumps.
      runExchange(makeReq(OP_SLT, 11'h000, 16'h0100, 16'h8000, 16'h0001), 10);
      runExchange(makeReq(OP_SLT, 11'h000, 16'h0102, 16'h7fff, 16'h8000), 0);
      runExchange(makeReq(OP_SLE, 11'h000, 16'h0104, 16'h8000, 16'h7fff), 0);
      runExchange(makeReq(OP_SLE, 11'h000, 16'h0106, 16'h1234, 16'h1234), 1);
      runExchange(makeReq(OP_SEQ, 11'h000, 16'h0108, 16'h8000, 16'h8000), 0);
      runExchange(makeReq(OP_SCO, 11'h000, 16'h010a, 16'hffff, 16'h0001), 0);
      runExchange(makeReq(OP_BTR, 11'h000, 16'h010c, 16'h0001, 16'h5555), 0);
      runExchange(makeReq(OP_BLTZ, 11'h0f0, 16'h010e, 16'h8000, 16'h0000), 0);
      runExchange(makeReq(OP_BGEZ, 11'h010, 16'h0110, 16'h0000, 16'h0000), 2);
      runExchange(makeReq(OP_BEQZ, 11'h07f, 16'h0112, 16'h0000, 16'h0000), 0);
      runExchange(makeReq(OP_JAL, 11'h400, 16'h0114, 16'h2222, 16'h0000), 0);
      runExchange(makeReq(OP_JALR, 11'h080, 16'h0116, 16'h1000, 16'h0000), 0);

      for (int n = 0; n < NUM_RANDOM; n++) begin
         randomBits(16, r.instr);             // All 32 opcodes, unknown ones too.
         randomBits(16, r.pc);
         randomBits(16, r.regA);
         randomBits(16, r.regB);
         randomBits(2, bits);
         if (bits[1:0] == 2'b00) r.regA = 16'h0000;  // Taken zero branches.
         randomBits(3, bits);
         runExchange(r, int'(bits[2:0]));
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Watchdog, twenty cycles per exchange plus reset.
   initial begin
      #((NUM_TX * 20 + RESET_CYCLES) * 10);
      $display("Timeout: the run did not finish in the expected time.");
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule
